// ==== rtl/mixer_pkg.sv ====
/*
 * Shared widths, layer codes and word layouts for the colour mixer.
 * Modules pull these in with a wildcard import of mixer_pkg.
 */
package mixer_pkg;

    // Raw pen widths from the generators
    localparam int SCR_W  = 11;
    localparam int OBJ_W  = 9;
    localparam int STAR_W = 7;

    // Six queue slots, four tile layers plus two stars
    localparam int N_LAYERS = 6;

    // Low nibble that marks a pen as see-through
    localparam logic [3:0] TRANSP_NIBBLE = 4'hf;

    // Layer codes as carried in the layer word
    localparam logic [2:0] LYR_OBJ  = 3'd0;
    localparam logic [2:0] LYR_SCR1 = 3'd1;
    localparam logic [2:0] LYR_SCR2 = 3'd2;
    localparam logic [2:0] LYR_SCR3 = 3'd3;
    // Bit 2 set means a star layer
    localparam logic [2:0] LYR_STA0 = 3'd4;
    localparam logic [2:0] LYR_STA1 = 3'd5;

    // Palette index, layer code over the 9-bit pen
    typedef logic [11:0] pen_t;

    // Colour word out of the palette
    typedef logic [15:0] rgb_t;

    // Queue word, group on top so {grp, pen_t} splits cleanly
    typedef struct packed {
        logic [1:0]       grp;
        logic [2:0]       code;
        logic [OBJ_W-1:0] pen;
    } layer_word_t;

    // Nothing opaque, fall back to the last palette entry
    localparam layer_word_t BLANK_DEFAULT = '{
        grp:  2'b11,
        code: 3'b111,
        pen:  9'h1ff
    };

endpackage

// ==== rtl/layer_gate.sv ====
/*
 * Input side of the mixer. Forces pens of disabled layers to transparent
 * and registers the star layer enables for the star generator.
 */
`timescale 1ns/100ps

module layer_gate (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [3:0]                    gfx_en,
    input  logic [3:1]                    scrdma_en,
    input  logic [15:0]                   layer_ctrl,
    input  logic [7:0]                    layer_mask0,
    input  logic [7:0]                    layer_mask1,
    input  logic [7:0]                    layer_mask2,
    input  logic [7:0]                    layer_mask3,
    input  logic [7:0]                    layer_mask4,
    input  logic [mixer_pkg::SCR_W-1:0]   scr1_pxl,
    input  logic [mixer_pkg::SCR_W-1:0]   scr2_pxl,
    input  logic [mixer_pkg::SCR_W-1:0]   scr3_pxl,
    input  logic [mixer_pkg::STAR_W-1:0]  star0_pxl,
    input  logic [mixer_pkg::STAR_W-1:0]  star1_pxl,
    input  logic [mixer_pkg::OBJ_W-1:0]   obj_pxl,
    output logic [mixer_pkg::OBJ_W-1:0]   obj_m,
    output logic [mixer_pkg::SCR_W-1:0]   scr1_m,
    output logic [mixer_pkg::SCR_W-1:0]   scr2_m,
    output logic [mixer_pkg::SCR_W-1:0]   scr3_m,
    output logic [mixer_pkg::STAR_W-1:0]  sta0_m,
    output logic [mixer_pkg::STAR_W-1:0]  sta1_m,
    output logic [1:0]                    star_en
);
    import mixer_pkg::*;

    // Layer on when any of its mask bits hits an enabled control bit
    function automatic logic mask_hit(input logic [7:0] mask, input logic [15:0] ctrl);
        mask_hit = |(mask[5:0] & ctrl[5:0]);
    endfunction

    logic [4:0] lyren;
    logic       scr1_on;
    logic       scr2_on;
    logic       scr3_on;

    // Index 0..2 scroll layers, 3..4 stars
    assign lyren[0] = mask_hit(layer_mask0, layer_ctrl);
    assign lyren[1] = mask_hit(layer_mask1, layer_ctrl);
    assign lyren[2] = mask_hit(layer_mask2, layer_ctrl);
    assign lyren[3] = mask_hit(layer_mask3, layer_ctrl);
    assign lyren[4] = mask_hit(layer_mask4, layer_ctrl);

    // Scroll layers also need tile DMA and the debug enable
    assign scr1_on = lyren[0] & scrdma_en[1] & gfx_en[0];
    assign scr2_on = lyren[1] & scrdma_en[2] & gfx_en[1];
    assign scr3_on = lyren[2] & scrdma_en[3] & gfx_en[2];

    // Objects ignore the masks, only gfx_en[3] hides them
    assign obj_m  = {obj_pxl[OBJ_W-1:4], obj_pxl[3:0] | (TRANSP_NIBBLE & {4{~gfx_en[3]}})};
    assign scr1_m = {scr1_pxl[SCR_W-1:4], scr1_pxl[3:0] | (TRANSP_NIBBLE & {4{~scr1_on}})};
    assign scr2_m = {scr2_pxl[SCR_W-1:4], scr2_pxl[3:0] | (TRANSP_NIBBLE & {4{~scr2_on}})};
    assign scr3_m = {scr3_pxl[SCR_W-1:4], scr3_pxl[3:0] | (TRANSP_NIBBLE & {4{~scr3_on}})};
    assign sta0_m = {star0_pxl[STAR_W-1:4], star0_pxl[3:0] | (TRANSP_NIBBLE & {4{~lyren[3]}})};
    assign sta1_m = {star1_pxl[STAR_W-1:4], star1_pxl[3:0] | (TRANSP_NIBBLE & {4{~lyren[4]}})};

    // Star generator enables, one clock behind the control inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            star_en <= 2'b00;
        end else begin
            star_en <= lyren[4:3];
        end
    end

endmodule

// ==== rtl/layer_order.sv ====
/*
 * Builds the six layer words in draw order, top slot first.
 * Slots 0..3 follow the selectors in layer_ctrl, slots 4..5 are the stars.
 */
`timescale 1ns/100ps

module layer_order (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic [15:0]                   layer_ctrl,
    input  logic [mixer_pkg::OBJ_W-1:0]   obj_m,
    input  logic [mixer_pkg::SCR_W-1:0]   scr1_m,
    input  logic [mixer_pkg::SCR_W-1:0]   scr2_m,
    input  logic [mixer_pkg::SCR_W-1:0]   scr3_m,
    input  logic [mixer_pkg::STAR_W-1:0]  sta0_m,
    input  logic [mixer_pkg::STAR_W-1:0]  sta1_m,
    output mixer_pkg::layer_word_t        lyr0,
    output mixer_pkg::layer_word_t        lyr1,
    output mixer_pkg::layer_word_t        lyr2,
    output mixer_pkg::layer_word_t        lyr3,
    output mixer_pkg::layer_word_t        lyr4,
    output mixer_pkg::layer_word_t        lyr5
);
    import mixer_pkg::*;

    // Scroll pen top bits carry the priority group
    function automatic layer_word_t scr_word(input logic [SCR_W-1:0] pen,
                                             input logic [2:0]       code);
        scr_word = '{grp: pen[SCR_W-1:SCR_W-2], code: code, pen: pen[OBJ_W-1:0]};
    endfunction

    // One slot, picked by a 2-bit selector
    function automatic layer_word_t layer_mux(input logic [1:0] sel);
        case (sel)
            2'd0:    layer_mux = '{grp: 2'b00, code: LYR_OBJ, pen: obj_m};
            2'd1:    layer_mux = scr_word(scr1_m, LYR_SCR1);
            2'd2:    layer_mux = scr_word(scr2_m, LYR_SCR2);
            default: layer_mux = scr_word(scr3_m, LYR_SCR3);
        endcase
    endfunction

    layer_word_t sta0_w;
    layer_word_t sta1_w;

    // Stars sit in group 0, pen zero-extended
    assign sta0_w = '{grp: 2'b00, code: LYR_STA0, pen: {{(OBJ_W-STAR_W){1'b0}}, sta0_m}};
    assign sta1_w = '{grp: 2'b00, code: LYR_STA1, pen: {{(OBJ_W-STAR_W){1'b0}}, sta1_m}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Start fully transparent
            lyr0 <= BLANK_DEFAULT;
            lyr1 <= BLANK_DEFAULT;
            lyr2 <= BLANK_DEFAULT;
            lyr3 <= BLANK_DEFAULT;
            lyr4 <= BLANK_DEFAULT;
            lyr5 <= BLANK_DEFAULT;
        end else if (pxl_cen) begin
            // Bits 13:12 pick the top slot
            lyr0 <= layer_mux(layer_ctrl[13:12]);
            lyr1 <= layer_mux(layer_ctrl[11:10]);
            lyr2 <= layer_mux(layer_ctrl[9:8]);
            lyr3 <= layer_mux(layer_ctrl[7:6]);
            lyr4 <= sta0_w;
            lyr5 <= sta1_w;
        end
    end

endmodule

// ==== rtl/prio_resolve.sv ====
/*
 * Walks the six layer words one per clock between pixel strobes and keeps
 * the first opaque pen, letting flagged scroll pens win over objects above.
 */
`timescale 1ns/100ps

module prio_resolve #(
    parameter mixer_pkg::layer_word_t blank_pen = mixer_pkg::BLANK_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  logic [15:0]             prio0,
    input  logic [15:0]             prio1,
    input  logic [15:0]             prio2,
    input  logic [15:0]             prio3,
    input  mixer_pkg::layer_word_t  lyr0,
    input  mixer_pkg::layer_word_t  lyr1,
    input  mixer_pkg::layer_word_t  lyr2,
    input  mixer_pkg::layer_word_t  lyr3,
    input  mixer_pkg::layer_word_t  lyr4,
    input  mixer_pkg::layer_word_t  lyr5,
    output mixer_pkg::pen_t         pxl_idx
);
    import mixer_pkg::*;

    localparam int QLEN = N_LAYERS - 1;

    // Slots still to visit, index 0 is the head
    layer_word_t lyr_queue [QLEN];

    // Current best pen and its group
    pen_t        cand;
    logic [1:0]  grp;

    layer_word_t head;
    layer_word_t below;
    logic [15:0] prio_sel;
    logic        has_prio;
    logic        obj_skip;
    logic        cand_transp;

    assign head  = lyr_queue[0];
    assign below = lyr_queue[1];

    // Priority mask of the group under consideration
    always_comb begin
        case (grp)
            2'd0:    prio_sel = prio0;
            2'd1:    prio_sel = prio1;
            2'd2:    prio_sel = prio2;
            default: prio_sel = prio3;
        endcase
    end

    // Stars and the blank filler never beat an object
    assign has_prio    = prio_sel[below.pen[3:0]] & ~below.code[2];
    assign obj_skip    = (head.code == LYR_OBJ) & has_prio;
    assign cand_transp = (cand[3:0] == TRANSP_NIBBLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_idx <= blank_pen[11:0];
            cand    <= blank_pen[11:0];
            grp     <= blank_pen.grp;
            for (int i = 0; i < QLEN; i++) begin
                lyr_queue[i] <= blank_pen;
            end
        end else if (pxl_cen) begin
            // Previous pixel is done, start the next one
            pxl_idx      <= cand;
            {grp, cand}  <= lyr0;
            lyr_queue[0] <= lyr1;
            lyr_queue[1] <= lyr2;
            lyr_queue[2] <= lyr3;
            lyr_queue[3] <= lyr4;
            lyr_queue[4] <= lyr5;
        end else begin
            // Advance one slot, refill tail with blank
            for (int i = 0; i < QLEN - 1; i++) begin
                lyr_queue[i] <= lyr_queue[i+1];
            end
            lyr_queue[QLEN-1] <= blank_pen;
            // See-through so far, take the head unless it gives way
            if (cand_transp && !obj_skip) begin
                {grp, cand} <= head;
            end
        end
    end

endmodule

// ==== rtl/palette_lut.sv ====
/*
 * Output side palette RAM. The host fills it through the write port and
 * each resolved pixel index is read out one clock after its strobe.
 */
`timescale 1ns/100ps

module palette_lut (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  mixer_pkg::pen_t  pxl_idx,
    input  logic             pal_we,
    input  logic [11:0]      pal_addr,
    input  mixer_pkg::rgb_t  pal_data,
    output mixer_pkg::rgb_t  rgb,
    output logic             rgb_valid
);
    import mixer_pkg::*;

    localparam int PAL_DEPTH = 4096;

    rgb_t       pal_ram [PAL_DEPTH];

    // Strobe delayed by one, pxl_idx is settled by then
    logic       rd_en;
    // Strobes seen since reset, saturates at 3
    logic [1:0] fill_cnt;
    logic       pipe_full;

    // Pixel pipeline needs three strobes before data is real
    assign pipe_full = (fill_cnt == 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en    <= 1'b0;
            fill_cnt <= 2'd0;
        end else begin
            rd_en <= pxl_cen;
            if (pxl_cen && !pipe_full) begin
                fill_cnt <= fill_cnt + 2'd1;
            end
        end
    end

    // Host write and pixel read on the same clock edge
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end
        // Same-address write is not seen until the next read
        if (rd_en) begin
            rgb <= pal_ram[pxl_idx];
        end
    end

    // One-clock pulse alongside each new colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= rd_en & pipe_full;
        end
    end

endmodule

// ==== rtl/layer_mixer_top.sv ====
/*
 * Colour mixer top level. Gates, orders and resolves six video layers
 * per pixel strobe and turns the winning pen into a palette colour.
 */
`timescale 1ns/100ps

module layer_mixer_top #(
    parameter mixer_pkg::layer_word_t blank_pen = mixer_pkg::BLANK_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic [3:0]                    gfx_en,
    input  logic [3:1]                    scrdma_en,
    input  logic [15:0]                   layer_ctrl,
    input  logic [7:0]                    layer_mask0,
    input  logic [7:0]                    layer_mask1,
    input  logic [7:0]                    layer_mask2,
    input  logic [7:0]                    layer_mask3,
    input  logic [7:0]                    layer_mask4,
    input  logic [15:0]                   prio0,
    input  logic [15:0]                   prio1,
    input  logic [15:0]                   prio2,
    input  logic [15:0]                   prio3,
    input  logic [mixer_pkg::SCR_W-1:0]   scr1_pxl,
    input  logic [mixer_pkg::SCR_W-1:0]   scr2_pxl,
    input  logic [mixer_pkg::SCR_W-1:0]   scr3_pxl,
    input  logic [mixer_pkg::STAR_W-1:0]  star0_pxl,
    input  logic [mixer_pkg::STAR_W-1:0]  star1_pxl,
    input  logic [mixer_pkg::OBJ_W-1:0]   obj_pxl,
    input  logic                          pal_we,
    input  logic [11:0]                   pal_addr,
    input  mixer_pkg::rgb_t               pal_data,
    output logic [1:0]                    star_en,
    output mixer_pkg::rgb_t               rgb,
    output logic                          rgb_valid
);
    import mixer_pkg::*;

    // Masked pens, combinational
    logic [OBJ_W-1:0]  obj_m;
    logic [SCR_W-1:0]  scr1_m, scr2_m, scr3_m;
    logic [STAR_W-1:0] sta0_m, sta1_m;

    // Draw-order slots, registered at the strobe
    layer_word_t lyr0, lyr1, lyr2, lyr3, lyr4, lyr5;

    // Resolved palette index
    pen_t pxl_idx;

    layer_gate gate_i (
        .clk, .rst_n, .gfx_en, .scrdma_en, .layer_ctrl,
        .layer_mask0, .layer_mask1, .layer_mask2, .layer_mask3, .layer_mask4,
        .scr1_pxl, .scr2_pxl, .scr3_pxl, .star0_pxl, .star1_pxl, .obj_pxl,
        .obj_m, .scr1_m, .scr2_m, .scr3_m, .sta0_m, .sta1_m, .star_en
    );

    layer_order order_i (
        .clk, .rst_n, .pxl_cen, .layer_ctrl,
        .obj_m, .scr1_m, .scr2_m, .scr3_m, .sta0_m, .sta1_m,
        .lyr0, .lyr1, .lyr2, .lyr3, .lyr4, .lyr5
    );

    prio_resolve #(
        .blank_pen(blank_pen)
    ) resolve_i (
        .clk, .rst_n, .pxl_cen, .prio0, .prio1, .prio2, .prio3,
        .lyr0, .lyr1, .lyr2, .lyr3, .lyr4, .lyr5, .pxl_idx
    );

    // Strobe forwarded so the read lands after pxl_idx moves
    palette_lut pal_i (
        .clk, .rst_n, .pxl_cen, .pxl_idx,
        .pal_we, .pal_addr, .pal_data, .rgb, .rgb_valid
    );

endmodule

// ==== sim/tb_clock.sv ====
/*
 * Testbench clock and power-on reset. Reset is held low for a set number
 * of cycles and released just after a rising edge.
 */
`timescale 1ns/100ps

module tb_clock #(
    parameter int period_ns  = 8,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // Release lands 1 ns after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== sim/tb_layer_mixer.sv ====
/*
 * Testbench for the colour mixer. Drives random layer pens and controls,
 * predicts each pixel colour with a reference model and checks rgb.
 */
`timescale 1ns/100ps

module tb_layer_mixer;
    import mixer_pkg::*;

    localparam int pix_count = 202;
    localparam int phase_len = 40;
    // Non-default blank word, low nibble still see-through
    localparam layer_word_t blank_word = '{grp: 2'b11, code: 3'b110, pen: 9'h07f};

    logic              clk, rst_n, pxl_cen, pal_we, rgb_valid;
    logic [3:0]        gfx_en;
    logic [3:1]        scrdma_en;
    logic [15:0]       layer_ctrl, prio0, prio1, prio2, prio3;
    logic [7:0]        layer_mask0, layer_mask1, layer_mask2, layer_mask3, layer_mask4;
    logic [SCR_W-1:0]  scr1_pxl, scr2_pxl, scr3_pxl;
    logic [STAR_W-1:0] star0_pxl, star1_pxl;
    logic [OBJ_W-1:0]  obj_pxl;
    logic [11:0]       pal_addr;
    rgb_t              pal_data, rgb, exp_rgb;
    logic [1:0]        star_en, star_exp;

    integer      seed = 62498;
    rgb_t        pal_model [4096];
    // Slot words of the last strobe, waiting for the prio seen in their walk
    layer_word_t pend [N_LAYERS];
    logic        have_pend = 1'b0;
    logic [11:0] exp_q [$];
    int          strobes = 0;
    int          checked = 0;

    tb_clock #(.period_ns(8), .rst_cycles(5)) clock_i (.clk, .rst_n);

    layer_mixer_top #(.blank_pen(blank_word)) dut_i (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic logic layer_enabled(input logic [7:0] mask);
        return |(mask[5:0] & layer_ctrl[5:0]);
    endfunction

    function automatic logic [10:0] rand_pen();
        logic [31:0] v;
        v = $random(seed);
        // About half the pens see-through
        if (v[31])
            v[3:0] = 4'hf;
        return v[10:0];
    endfunction

    // Index 0..2 scroll, 3..4 stars, 5 object
    task automatic pick_stimulus(input int phase);
        logic [31:0] v;
        logic [10:0] p [6];
        for (int i = 0; i < 6; i++) begin
            p[i] = rand_pen();
            if (phase == 4) begin
                // Few distinct indices so palette rewrites get hit
                if (p[i][3:0] != 4'hf)
                    p[i][3:2] = 2'b00;
                p[i][8:4] = 5'd0;
            end
        end
        v = $random(seed);
        layer_ctrl = v[15:0];
        prio0 = v[31:16];
        v = $random(seed);
        prio1 = v[15:0];
        prio2 = v[31:16];
        v = $random(seed);
        prio3 = v[15:0];
        gfx_en = 4'hf;
        scrdma_en = 3'h7;
        {layer_mask0, layer_mask1, layer_mask2, layer_mask3, layer_mask4} = {5{8'hff}};
        layer_ctrl[5:0] = 6'h3f;
        case (phase)
            1: begin
                // Random enables, layers drop out
                gfx_en = v[19:16];
                scrdma_en = v[22:20];
                layer_ctrl[5:0] = v[28:23];
                v = $random(seed);
                {layer_mask0, layer_mask1, layer_mask2, layer_mask3} = v;
                layer_mask4 = {v[3:0], v[31:28]};
            end
            2: begin
                // See-through scroll on top, opaque object right under it
                layer_ctrl[13:12] = (v[17:16] == 2'd0) ? 2'd1 : v[17:16];
                layer_ctrl[11:10] = 2'd0;
                p[layer_ctrl[13:12] - 2'd1][3:0] = 4'hf;
                p[5][0] = 1'b0;
                // Dense masks so the skip fires often
                v = $random(seed);
                prio0 = prio0 | v[15:0];
                prio1 = prio1 | v[31:16];
                v = $random(seed);
                prio2 = prio2 | v[15:0];
                prio3 = prio3 | v[31:16];
            end
            3: begin
                // Nothing opaque, masked off or pens see-through
                if (v[16]) begin
                    gfx_en = 4'h0;
                    layer_mask3 = 8'h00;
                    layer_mask4 = 8'h00;
                end else begin
                    for (int i = 0; i < 6; i++)
                        p[i][3:0] = 4'hf;
                end
            end
            default: ;
        endcase
        scr1_pxl = p[0];
        scr2_pxl = p[1];
        scr3_pxl = p[2];
        star0_pxl = p[3][6:0];
        star1_pxl = p[4][6:0];
        obj_pxl = p[5][8:0];
    endtask

    // Slot words from the inputs now on the pins
    task automatic build_slots();
        logic [10:0] scr [3];
        logic [8:0]  obj;
        logic [6:0]  st0;
        logic [6:0]  st1;
        logic [1:0]  sel;
        scr[0] = scr1_pxl;
        scr[1] = scr2_pxl;
        scr[2] = scr3_pxl;
        obj = obj_pxl;
        st0 = star0_pxl;
        st1 = star1_pxl;
        // Disabled layer reads as see-through
        if (!(layer_enabled(layer_mask0) && scrdma_en[1] && gfx_en[0]))
            scr[0][3:0] = 4'hf;
        if (!(layer_enabled(layer_mask1) && scrdma_en[2] && gfx_en[1]))
            scr[1][3:0] = 4'hf;
        if (!(layer_enabled(layer_mask2) && scrdma_en[3] && gfx_en[2]))
            scr[2][3:0] = 4'hf;
        if (!gfx_en[3])
            obj[3:0] = 4'hf;
        if (!layer_enabled(layer_mask3))
            st0[3:0] = 4'hf;
        if (!layer_enabled(layer_mask4))
            st1[3:0] = 4'hf;
        for (int s = 0; s < 4; s++) begin
            sel = layer_ctrl[13 - 2*s -: 2];
            if (sel == 2'd0) begin
                pend[s] = '{grp: 2'b00, code: LYR_OBJ, pen: obj};
            end else begin
                pend[s] = '{grp: scr[sel-2'd1][10:9], code: {1'b0, sel},
                            pen: scr[sel-2'd1][8:0]};
            end
        end
        pend[4] = '{grp: 2'b00, code: LYR_STA0, pen: {2'b00, st0}};
        pend[5] = '{grp: 2'b00, code: LYR_STA1, pen: {2'b00, st1}};
    endtask

    // First opaque slot from the top, objects yield to a flagged layer below
    task automatic resolve_pending();
        logic [11:0] cand;
        logic [1:0]  grp;
        logic [15:0] pmask;
        layer_word_t below;
        logic        skip;
        cand = {pend[0].code, pend[0].pen};
        grp = pend[0].grp;
        for (int j = 1; j < N_LAYERS; j++) begin
            below = (j < N_LAYERS - 1) ? pend[j+1] : blank_word;
            pmask = (grp == 2'd0) ? prio0 : (grp == 2'd1) ? prio1 : (grp == 2'd2) ? prio2 : prio3;
            skip = (pend[j].code == LYR_OBJ) && !below.code[2] && pmask[below.pen[3:0]];
            if (cand[3:0] == 4'hf && !skip) begin
                cand = {pend[j].code, pend[j].pen};
                grp = pend[j].grp;
            end
        end
        if (cand[3:0] == 4'hf)
            cand = {blank_word.code, blank_word.pen};
        exp_q.push_back(cand);
    endtask

    // One pixel period, strobe first and a palette write mid-way
    task automatic run_pixel(input int phase);
        logic [31:0] v;
        @(posedge clk);
        #1;
        pick_stimulus(phase);
        pxl_cen = 1'b1;
        // Previous pixel walks under the prio masks just driven
        if (have_pend)
            resolve_pending();
        build_slots();
        have_pend = 1'b1;
        for (int c = 1; c < 8; c++) begin
            @(posedge clk);
            #1;
            pxl_cen = 1'b0;
            pal_we = 1'b0;
            if (c == 4) begin
                v = $random(seed);
                pal_we = (phase == 4) || (v[17:16] == 2'd0);
                pal_addr = (phase == 4) ? {v[2:0], 7'd0, v[4:3]} : v[11:0];
                pal_data = v[31:16];
                if (pal_we)
                    pal_model[pal_addr] = pal_data;
            end
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            star_exp <= 2'b00;
        else
            star_exp <= {layer_enabled(layer_mask4), layer_enabled(layer_mask3)};
    end

    always @(posedge clk) begin
        if (pxl_cen === 1'b1)
            strobes++;
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        assert (star_en === star_exp)
        else fail_run($sformatf("Mismatch star_en: expected %h, got %h", star_exp, star_en));
        if (rgb_valid !== 1'b0) begin
            assert (strobes >= 3 && exp_q.size() > 0)
            else fail_run("rgb_valid pulsed before any pixel could reach the output");
            exp_rgb = pal_model[exp_q.pop_front()];
            assert (rgb === exp_rgb)
            else fail_run($sformatf("Mismatch rgb: expected %h, got %h", exp_rgb, rgb));
            checked++;
        end
    end

    initial begin
        {pxl_cen, pal_we, pal_addr, pal_data} = '0;
        {gfx_en, scrdma_en, layer_ctrl} = '0;
        {prio0, prio1, prio2, prio3} = '0;
        {layer_mask0, layer_mask1, layer_mask2, layer_mask3, layer_mask4} = '0;
        {scr1_pxl, scr2_pxl, scr3_pxl, star0_pxl, star1_pxl, obj_pxl} = '0;
        for (int n = 0; n < 20 && rst_n !== 1'b1; n++)
            @(posedge clk);
        if (rst_n !== 1'b1)
            fail_run("Timeout waiting for reset release");
        // Whole palette first, model keeps a copy
        for (int a = 0; a < 4096; a++) begin
            @(posedge clk);
            #1;
            pal_we = 1'b1;
            pal_addr = a[11:0];
            pal_data = $random(seed);
            pal_model[a] = pal_data;
        end
        for (int k = 0; k < pix_count; k++)
            run_pixel(k / phase_len);
        for (int n = 0; n < 40 && checked < pix_count - 2; n++)
            @(posedge clk);
        if (checked == pix_count - 2) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("Timeout waiting for the last pixel colours on rgb");
        end
    end

endmodule

// ==== layer_mixer.f ====
rtl/mixer_pkg.sv
rtl/layer_gate.sv
rtl/layer_order.sv
rtl/prio_resolve.sv
rtl/palette_lut.sv
rtl/layer_mixer_top.sv
sim/tb_clock.sv
sim/tb_layer_mixer.sv

// ==== Bender.yml ====
package:
  name: layer_mixer

sources:
  - rtl/mixer_pkg.sv
  - rtl/layer_gate.sv
  - rtl/layer_order.sv
  - rtl/prio_resolve.sv
  - rtl/palette_lut.sv
  - rtl/layer_mixer_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_layer_mixer.sv

# Simulation top: tb_layer_mixer
# Synthesis top: layer_mixer_top
# File list for other tools: layer_mixer.f
